/* alu_axil_top.f */
source/alu_pkg.sv
source/alu.sv
source/alu_fault_check.sv
source/alu_result_capture.sv
source/alu_axil_regs.sv
source/alu_axil_top.sv
verification/alu_axil_tb.sv

/* source/alu.sv */
`timescale 1ns/1ns

module alu (
	input  alu_pkg::word_t   a,           // First operand (rs)
	input  alu_pkg::word_t   b,           // Second operand (rt)
	input  alu_pkg::opcode_t operation,   // Operation select
	input  alu_pkg::shamt_t  shamt,       // Shift amount for SLL
	input  logic             equal,       // Branch on equal or not equal
	output alu_pkg::word_t   result,
	output logic             alu_zero,    // Branch taken
	output logic             movn         // Register write enable for MOVN
);

	always_comb begin
		result   = '0;   // Defined default instead of don't care
		alu_zero = 1'b0;
		movn     = 1'b0;

		case (operation)
			alu_pkg::OP_AND: begin
				result = a & b;
			end

			alu_pkg::OP_OR: begin
				result = a | b;
			end

			alu_pkg::OP_ADD,
			alu_pkg::OP_ADDU: begin
				result = a + b;   // Same bits signed or not
			end

			alu_pkg::OP_MOVN: begin
				if (b != '0) begin   // rt nonzero
					result = a;       // rd gets rs
					movn   = 1'b1;
				end
			end

			alu_pkg::OP_SLL: begin
				result = b << shamt;
			end

			alu_pkg::OP_SUB: begin
				result = a - b;
				// Zero flag follows BEQ or BNE sense
				alu_zero = (a == b) ? equal : ~equal;
			end

			alu_pkg::OP_SUBU: begin
				result = a - b;
			end

			alu_pkg::OP_BGEZ: begin
				if (!a[31]) begin   // rs >= 0 signed
					result   = 32'd1;
					alu_zero = 1'b1;
				end
			end

			alu_pkg::OP_SLT: begin
				result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			end

			alu_pkg::OP_SLTU: begin
				result = (a < b) ? 32'd1 : 32'd0;
			end

			alu_pkg::OP_NOR: begin
				result = ~(a | b);
			end

			alu_pkg::OP_XOR: begin
				result = a ^ b;
			end

			alu_pkg::OP_LUI: begin
				result = b << 16;   // Low half moves to upper half
			end

			default: begin
				result = alu_pkg::ILLEGAL_RESULT;   // Codes 11 and 14
			end
		endcase
	end

endmodule

/* source/alu_axil_regs.sv */
`timescale 1ns/1ns

module alu_axil_regs #(
	parameter int ADDR_WIDTH  = 8,
	parameter int COUNT_WIDTH = 16
) (
	input  logic                   clk,
	input  logic                   rst_n,
	// Write address and data
	input  logic [ADDR_WIDTH-1:0]  awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  alu_pkg::word_t         wdata,
	input  logic [3:0]             wstrb,      // Whole words only, strobes ignored
	input  logic                   wvalid,
	output logic                   wready,
	// Write response
	output alu_pkg::resp_t         bresp,
	output logic                   bvalid,
	input  logic                   bready,
	// Read address and data
	input  logic [ADDR_WIDTH-1:0]  araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output alu_pkg::word_t         rdata,
	output alu_pkg::resp_t         rresp,
	output logic                   rvalid,
	input  logic                   rready,
	// To the ALU and fault checker
	output alu_pkg::word_t         operand_a,
	output alu_pkg::word_t         operand_b,
	output alu_pkg::opcode_t       operation,
	output alu_pkg::shamt_t        shamt,
	output logic                   equal,
	output logic                   launch,     // One cycle per CTRL write
	// From the capture stage
	input  alu_pkg::word_t         result_q,
	input  logic [4:0]             status_q,
	input  logic [COUNT_WIDTH-1:0] op_count
);

	logic                  wr_hs;     // Both write channels accepted
	logic                  wr_pend;   // Response due next edge
	logic                  rd_pend;   // Read data due next edge
	logic [ADDR_WIDTH-1:0] rd_addr;   // Latched read offset
	alu_pkg::word_t        rd_mux;
	alu_pkg::resp_t        rd_resp;

	assign wr_hs = awready && awvalid && wready && wvalid;

	// Write side
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			awready   <= 1'b0;
			wready    <= 1'b0;
			bvalid    <= 1'b0;
			bresp     <= alu_pkg::RESP_OKAY;
			wr_pend   <= 1'b0;
			launch    <= 1'b0;
			operand_a <= '0;
			operand_b <= '0;
			operation <= '0;
			shamt     <= '0;
			equal     <= 1'b0;
		end else begin
			launch <= 1'b0;   // Pulse by default low
			if (wr_hs) begin
				awready <= 1'b0;
				wready  <= 1'b0;
				wr_pend <= 1'b1;
				bresp   <= alu_pkg::RESP_OKAY;
				if (awaddr == ADDR_WIDTH'(alu_pkg::REG_A)) begin
					operand_a <= wdata;
				end else if (awaddr == ADDR_WIDTH'(alu_pkg::REG_B)) begin
					operand_b <= wdata;
				end else if (awaddr == ADDR_WIDTH'(alu_pkg::REG_CTRL)) begin
					operation <= wdata[alu_pkg::CTRL_OP_LSB +: $bits(alu_pkg::opcode_t)];
					shamt     <= wdata[alu_pkg::CTRL_SHAMT_LSB +: $bits(alu_pkg::shamt_t)];
					equal     <= wdata[alu_pkg::CTRL_EQUAL_BIT];
					launch    <= 1'b1;   // Start the operation
				end else begin
					bresp <= alu_pkg::RESP_SLVERR;   // Read-only or unmapped
				end
			end else if (wr_pend) begin
				wr_pend <= 1'b0;
				bvalid  <= 1'b1;
			end else if (bvalid) begin
				if (bready) begin
					bvalid <= 1'b0;
				end
			end else if (!awready && awvalid && wvalid) begin
				awready <= 1'b1;   // Accept address and data together
				wready  <= 1'b1;
			end
		end
	end

	// Read data select
	always_comb begin
		rd_mux  = '0;
		rd_resp = alu_pkg::RESP_OKAY;
		if (rd_addr == ADDR_WIDTH'(alu_pkg::REG_A)) begin
			rd_mux = operand_a;
		end else if (rd_addr == ADDR_WIDTH'(alu_pkg::REG_B)) begin
			rd_mux = operand_b;
		end else if (rd_addr == ADDR_WIDTH'(alu_pkg::REG_CTRL)) begin
			rd_mux[alu_pkg::CTRL_OP_LSB +: $bits(alu_pkg::opcode_t)]   = operation;
			rd_mux[alu_pkg::CTRL_SHAMT_LSB +: $bits(alu_pkg::shamt_t)] = shamt;
			rd_mux[alu_pkg::CTRL_EQUAL_BIT]                            = equal;
		end else if (rd_addr == ADDR_WIDTH'(alu_pkg::REG_RESULT)) begin
			rd_mux = result_q;
		end else if (rd_addr == ADDR_WIDTH'(alu_pkg::REG_STATUS)) begin
			rd_mux = alu_pkg::word_t'(status_q);   // Zero-extended
		end else if (rd_addr == ADDR_WIDTH'(alu_pkg::REG_COUNT)) begin
			rd_mux = alu_pkg::word_t'(op_count);
		end else begin
			rd_resp = alu_pkg::RESP_SLVERR;   // Unmapped, data stays zero
		end
	end

	// Read side
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rd_pend <= 1'b0;
			rd_addr <= '0;
			rdata   <= '0;
			rresp   <= alu_pkg::RESP_OKAY;
		end else if (arready && arvalid) begin
			arready <= 1'b0;
			rd_pend <= 1'b1;
			rd_addr <= araddr;
		end else if (rd_pend) begin
			rd_pend <= 1'b0;
			rvalid  <= 1'b1;
			rdata   <= rd_mux;   // Held until rready
			rresp   <= rd_resp;
		end else if (rvalid) begin
			if (rready) begin
				rvalid <= 1'b0;
			end
		end else begin
			arready <= 1'b1;   // Idle, ready for an address
		end
	end

	bvalid_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid
	) else $error("bvalid dropped before bready");

	rdata_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
	) else $error("read data changed while waiting for rready");

endmodule

/* source/alu_axil_top.sv */
`timescale 1ns/1ns

module alu_axil_top #(
	parameter int ADDR_WIDTH  = 8,
	parameter int COUNT_WIDTH = 16
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [ADDR_WIDTH-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  alu_pkg::word_t        wdata,
	input  logic [3:0]            wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output alu_pkg::resp_t        bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [ADDR_WIDTH-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output alu_pkg::word_t        rdata,
	output alu_pkg::resp_t        rresp,
	output logic                  rvalid,
	input  logic                  rready
);

	alu_pkg::word_t         operand_a;
	alu_pkg::word_t         operand_b;
	alu_pkg::opcode_t       operation;
	alu_pkg::shamt_t        shamt;
	logic                   equal;
	logic                   launch;
	alu_pkg::word_t         result;     // Combinational ALU output
	logic                   alu_zero;
	logic                   movn;
	logic                   overflow;   // From the fault checker
	logic                   illegal;
	alu_pkg::word_t         result_q;   // Captured for reads
	logic [4:0]             status_q;
	logic [COUNT_WIDTH-1:0] op_count;

	alu_axil_regs #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.operation (operation),
		.shamt     (shamt),
		.equal     (equal),
		.launch    (launch),
		.result_q  (result_q),
		.status_q  (status_q),
		.op_count  (op_count)
	);

	// ALU and fault checker see the same operands
	alu u_alu (
		.a         (operand_a),
		.b         (operand_b),
		.operation (operation),
		.shamt     (shamt),
		.equal     (equal),
		.result    (result),
		.alu_zero  (alu_zero),
		.movn      (movn)
	);

	alu_fault_check u_fault (
		.a         (operand_a),
		.b         (operand_b),
		.operation (operation),
		.overflow  (overflow),
		.illegal   (illegal)
	);

	alu_result_capture #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_capture (
		.clk      (clk),
		.rst_n    (rst_n),
		.launch   (launch),
		.result   (result),
		.alu_zero (alu_zero),
		.movn     (movn),
		.overflow (overflow),
		.illegal  (illegal),
		.result_q (result_q),
		.status_q (status_q),
		.op_count (op_count)
	);

endmodule

/* source/alu_fault_check.sv */
`timescale 1ns/1ns

module alu_fault_check (
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	input  alu_pkg::opcode_t operation,
	output logic             overflow,   // Signed overflow on ADD or SUB
	output logic             illegal     // Opcode not in the set
);

	alu_pkg::word_t sum;
	alu_pkg::word_t diff;

	assign sum  = a + b;   // Own adder beside the ALU
	assign diff = a - b;

	// Overflow decode
	always_comb begin
		overflow = 1'b0;

		case (operation)
			alu_pkg::OP_ADD: begin
				// Same-sign operands, sum sign flipped
				overflow = (a[31] == b[31]) && (sum[31] != a[31]);
			end

			alu_pkg::OP_SUB: begin
				// Opposite signs, result sign differs from a
				overflow = (a[31] != b[31]) && (diff[31] != a[31]);
			end

			default: begin
				overflow = 1'b0;   // Unsigned and logic ops never flag
			end
		endcase
	end

	// Legal opcode decode, kept apart from the overflow decode
	always_comb begin
		case (operation)
			alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_ADD, alu_pkg::OP_ADDU,
			alu_pkg::OP_MOVN, alu_pkg::OP_SLL, alu_pkg::OP_SUB, alu_pkg::OP_SUBU,
			alu_pkg::OP_BGEZ, alu_pkg::OP_SLT, alu_pkg::OP_SLTU, alu_pkg::OP_NOR,
			alu_pkg::OP_XOR, alu_pkg::OP_LUI: begin
				illegal = 1'b0;
			end

			default: begin
				illegal = 1'b1;   // Codes 11 and 14
			end
		endcase
	end

	// Overflow must only come from codes the legal decode accepts
	always_comb begin
		ovf_vs_illegal: assert final (!(overflow && illegal))
			else $error("overflow and illegal both high for opcode %0d", operation);
	end

endmodule

/* source/alu_pkg.sv */
package alu_pkg;

	typedef logic [31:0] word_t;      // Operands, results, bus data
	typedef logic [3:0]  opcode_t;    // ALU operation code
	typedef logic [4:0]  shamt_t;     // Shift amount
	typedef logic [7:0]  reg_off_t;   // Register byte offset
	typedef logic [1:0]  resp_t;      // AXI response code

	localparam opcode_t OP_AND  = 4'd0;
	localparam opcode_t OP_OR   = 4'd1;
	localparam opcode_t OP_ADD  = 4'd2;   // Signed add
	localparam opcode_t OP_ADDU = 4'd3;
	localparam opcode_t OP_MOVN = 4'd4;   // Move if b nonzero
	localparam opcode_t OP_SLL  = 4'd5;
	localparam opcode_t OP_SUB  = 4'd6;   // Also BEQ/BNE compare
	localparam opcode_t OP_SUBU = 4'd7;
	localparam opcode_t OP_BGEZ = 4'd8;
	localparam opcode_t OP_SLT  = 4'd9;
	localparam opcode_t OP_SLTU = 4'd10;
	localparam opcode_t OP_NOR  = 4'd12;
	localparam opcode_t OP_XOR  = 4'd13;
	localparam opcode_t OP_LUI  = 4'd15;

	localparam reg_off_t REG_A      = 8'h00;
	localparam reg_off_t REG_B      = 8'h04;
	localparam reg_off_t REG_CTRL   = 8'h08;   // Write launches an operation
	localparam reg_off_t REG_RESULT = 8'h0C;
	localparam reg_off_t REG_STATUS = 8'h10;
	localparam reg_off_t REG_COUNT  = 8'h14;

	localparam int CTRL_OP_LSB    = 0;   // 4-bit opcode field
	localparam int CTRL_SHAMT_LSB = 4;   // 5-bit shift field
	localparam int CTRL_EQUAL_BIT = 9;   // BEQ when set, BNE when clear

	localparam int ST_ZERO       = 0;   // Branch flag
	localparam int ST_MOVN       = 1;   // MOVN write enable
	localparam int ST_OVF        = 2;   // Overflow, last op
	localparam int ST_ILLEGAL    = 3;   // Unused opcode
	localparam int ST_OVF_STICKY = 4;   // Any overflow since reset

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	localparam word_t ILLEGAL_RESULT = 32'hDEADBEEF;

endpackage

/* source/alu_result_capture.sv */
`timescale 1ns/1ns

module alu_result_capture #(
	parameter int COUNT_WIDTH = 16
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   launch,     // Pulse per CTRL write
	input  alu_pkg::word_t         result,
	input  logic                   alu_zero,
	input  logic                   movn,
	input  logic                   overflow,
	input  logic                   illegal,
	output alu_pkg::word_t         result_q,
	output logic [4:0]             status_q,
	output logic [COUNT_WIDTH-1:0] op_count    // Wraps on overflow
);

	logic launch_q;   // Capture strobe, cycle after launch

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			launch_q <= 1'b0;
		end else begin
			launch_q <= launch;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_q <= '0;
			status_q <= '0;
			op_count <= '0;
		end else if (launch_q) begin
			result_q                        <= result;
			status_q[alu_pkg::ST_ZERO]      <= alu_zero;
			status_q[alu_pkg::ST_MOVN]      <= movn;
			status_q[alu_pkg::ST_OVF]       <= overflow;   // Per operation
			status_q[alu_pkg::ST_ILLEGAL]   <= illegal;
			// Sticky bit accumulates until reset
			status_q[alu_pkg::ST_OVF_STICKY] <= status_q[alu_pkg::ST_OVF_STICKY] | overflow;
			op_count                        <= op_count + 1'b1;
		end
	end

	// Sticky overflow only clears by reset
	sticky_holds: assert property (
		@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> !$fell(status_q[alu_pkg::ST_OVF_STICKY])
	) else $error("sticky overflow bit fell without reset");

endmodule

/* verification/alu_axil_tb.sv */
`timescale 1ns/1ns

module alu_axil_tb;

	localparam int TIMEOUT = 20;   // Cycles per wait loop

	logic                  clk;
	logic                  rst_n;
	alu_pkg::reg_off_t     awaddr;
	logic                  awvalid;
	logic                  awready;
	alu_pkg::word_t        wdata;
	logic [3:0]            wstrb;
	logic                  wvalid;
	logic                  wready;
	alu_pkg::resp_t        bresp;
	logic                  bvalid;
	logic                  bready;
	alu_pkg::reg_off_t     araddr;
	logic                  arvalid;
	logic                  arready;
	alu_pkg::word_t        rdata;
	alu_pkg::resp_t        rresp;
	logic                  rvalid;
	logic                  rready;

	int             errors      = 0;
	int             checks      = 0;
	int             ctrl_writes = 0;   // CTRL writes since reset
	int             ready_stall = 0;   // Cycles to hold bready/rready low
	logic           sticky_exp  = 1'b0;
	alu_pkg::word_t last_result = '0;

	alu_pkg::word_t bounds [5] = '{32'h0000_0000, 32'h0000_0001, 32'h7FFF_FFFF,
		32'h8000_0000, 32'hFFFF_FFFF};   // Sign-boundary operands
	alu_pkg::opcode_t arith_ops [14] = '{alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_ADD,
		alu_pkg::OP_ADDU, alu_pkg::OP_MOVN, alu_pkg::OP_SLL, alu_pkg::OP_SUB,
		alu_pkg::OP_SUBU, alu_pkg::OP_BGEZ, alu_pkg::OP_SLT, alu_pkg::OP_SLTU,
		alu_pkg::OP_NOR, alu_pkg::OP_XOR, alu_pkg::OP_LUI};

	alu_axil_top dut (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	always #20 clk = ~clk;   // 40 ns period

	task automatic check_value(input string name, input alu_pkg::word_t exp,
		input alu_pkg::word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %h got %h", name, exp, act);
		end
	endtask

	// Result and status bits 0..3 straight from the opcode rules
	function automatic alu_pkg::word_t model_op(input alu_pkg::word_t a, input alu_pkg::word_t b,
		input alu_pkg::opcode_t op, input alu_pkg::shamt_t sh, input logic eq,
		output logic [4:0] flags);
		logic [32:0]    wide;   // Sign-extended for overflow
		alu_pkg::word_t r;
		r     = '0;
		flags = '0;
		case (op)
			alu_pkg::OP_AND:  r = a & b;
			alu_pkg::OP_OR:   r = a | b;
			alu_pkg::OP_NOR:  r = ~(a | b);
			alu_pkg::OP_XOR:  r = a ^ b;
			alu_pkg::OP_ADDU: r = a + b;
			alu_pkg::OP_SUBU: r = a - b;
			alu_pkg::OP_SLL:  r = b << sh;
			alu_pkg::OP_LUI:  r = {b[15:0], 16'h0000};
			alu_pkg::OP_SLT:  r = {31'd0, $signed(a) < $signed(b)};
			alu_pkg::OP_SLTU: r = {31'd0, a < b};
			alu_pkg::OP_ADD: begin
				wide = {a[31], a} + {b[31], b};
				r = wide[31:0];
				flags[alu_pkg::ST_OVF] = wide[32] ^ wide[31];   // Sign bits disagree
			end
			alu_pkg::OP_SUB: begin
				wide = {a[31], a} - {b[31], b};
				r = wide[31:0];
				flags[alu_pkg::ST_OVF]  = wide[32] ^ wide[31];
				flags[alu_pkg::ST_ZERO] = ((a == b) == eq);   // BEQ or BNE sense
			end
			alu_pkg::OP_MOVN: begin
				if (b != 0) begin
					r = a;
					flags[alu_pkg::ST_MOVN] = 1'b1;
				end
			end
			alu_pkg::OP_BGEZ: begin
				if ($signed(a) >= 0) begin
					r = 32'd1;
					flags[alu_pkg::ST_ZERO] = 1'b1;
				end
			end
			default: begin
				r = alu_pkg::ILLEGAL_RESULT;   // Codes 11 and 14
				flags[alu_pkg::ST_ILLEGAL] = 1'b1;
			end
		endcase
		return r;
	endfunction

	task automatic axil_write(input alu_pkg::reg_off_t offset, input alu_pkg::word_t data,
		input alu_pkg::resp_t exp_resp);
		int n;
		awaddr  = offset;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = (ready_stall == 0);
		n = 0;
		while (!(awready && wready) && n < TIMEOUT) begin   // Handshake on next edge
			@(negedge clk);
			n++;
		end
		if (n >= TIMEOUT) begin
			errors++;
			$display("Timeout waiting for awready and wready at offset %h", offset);
		end
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		while (!bvalid && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (n >= TIMEOUT) begin
			errors++;
			$display("Timeout waiting for the write response at offset %h", offset);
		end else begin
			check_value("bresp", exp_resp, bresp);
			for (int i = 0; i < ready_stall; i++) begin
				@(negedge clk);
				check_value("bvalid", 1, bvalid);   // Must hold without bready
			end
			if (ready_stall > 0) begin
				@(posedge clk);
				#1;
				bready = 1'b1;
			end
		end
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axil_read(input alu_pkg::reg_off_t offset, output alu_pkg::word_t data,
		input alu_pkg::resp_t exp_resp);
		int n;
		data    = '0;
		araddr  = offset;
		arvalid = 1'b1;
		rready  = (ready_stall == 0);
		n = 0;
		while (!arready && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (n >= TIMEOUT) begin
			errors++;
			$display("Timeout waiting for arready at offset %h", offset);
		end
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		n = 0;
		while (!rvalid && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (n >= TIMEOUT) begin
			errors++;
			$display("Timeout waiting for read data at offset %h", offset);
		end else begin
			data = rdata;
			check_value("rresp", exp_resp, rresp);
			for (int i = 0; i < ready_stall; i++) begin
				@(negedge clk);
				check_value("rvalid", 1, rvalid);
				check_value("rdata", data, rdata);   // Held while stalled
			end
			if (ready_stall > 0) begin
				@(posedge clk);
				#1;
				rready = 1'b1;
			end
		end
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic run_op(input alu_pkg::word_t a, input alu_pkg::word_t b,
		input alu_pkg::opcode_t op, input alu_pkg::shamt_t sh, input logic eq);
		alu_pkg::word_t ctrl;
		alu_pkg::word_t res_exp;
		alu_pkg::word_t got;
		logic [4:0]     flags;
		ctrl = '0;
		ctrl[alu_pkg::CTRL_OP_LSB +: 4]    = op;
		ctrl[alu_pkg::CTRL_SHAMT_LSB +: 5] = sh;
		ctrl[alu_pkg::CTRL_EQUAL_BIT]      = eq;
		res_exp = model_op(a, b, op, sh, eq, flags);
		sticky_exp = sticky_exp | flags[alu_pkg::ST_OVF];
		flags[alu_pkg::ST_OVF_STICKY] = sticky_exp;
		axil_write(alu_pkg::REG_A, a, alu_pkg::RESP_OKAY);
		axil_write(alu_pkg::REG_B, b, alu_pkg::RESP_OKAY);
		axil_write(alu_pkg::REG_CTRL, ctrl, alu_pkg::RESP_OKAY);
		ctrl_writes++;
		last_result = res_exp;
		axil_read(alu_pkg::REG_RESULT, got, alu_pkg::RESP_OKAY);
		check_value("result", res_exp, got);
		axil_read(alu_pkg::REG_STATUS, got, alu_pkg::RESP_OKAY);
		check_value("status", alu_pkg::word_t'(flags), got);
	endtask

	task automatic test_overflow();
		run_op(32'd1, 32'd2, alu_pkg::OP_ADD, 0, 0);   // Sticky still clear
		run_op(32'h7FFF_FFFF, 32'd1, alu_pkg::OP_ADD, 0, 0);
		run_op(32'h7FFF_FFFF, 32'd1, alu_pkg::OP_ADDU, 0, 0);
		run_op(32'h8000_0000, 32'd1, alu_pkg::OP_SUB, 0, 0);
	endtask

	task automatic test_random_ops();
		alu_pkg::word_t a;
		alu_pkg::word_t b;
		foreach (arith_ops[k]) begin
			for (int i = 0; i < 20; i++) begin
				if (i < 5) begin
					a = bounds[i];
					b = bounds[(i + 2) % 5];
				end else begin
					a = $urandom();
					b = $urandom();
				end
				run_op(a, b, arith_ops[k], alu_pkg::shamt_t'($urandom()), $urandom() & 1);
			end
		end
	endtask

	task automatic test_branch_movn();
		run_op(32'd5, 32'd5, alu_pkg::OP_SUB, 0, 1);   // BEQ taken
		run_op(32'd5, 32'd6, alu_pkg::OP_SUB, 0, 1);
		run_op(32'd5, 32'd5, alu_pkg::OP_SUB, 0, 0);   // BNE not taken
		run_op(32'd5, 32'd6, alu_pkg::OP_SUB, 0, 0);
		run_op(32'hFFFF_FFFD, 32'd0, alu_pkg::OP_BGEZ, 0, 0);
		run_op(32'd0, 32'd0, alu_pkg::OP_BGEZ, 0, 0);
		run_op(32'd7, 32'd0, alu_pkg::OP_BGEZ, 0, 0);
		run_op(32'h1234_5678, 32'd0, alu_pkg::OP_MOVN, 0, 0);
		run_op(32'h1234_5678, 32'd9, alu_pkg::OP_MOVN, 0, 0);
	endtask

	task automatic test_illegal();
		run_op(32'd3, 32'd4, 4'd11, 0, 0);
		run_op(32'd3, 32'd4, 4'd14, 0, 0);
	endtask

	task automatic test_bus_errors();
		alu_pkg::word_t got;
		axil_read(alu_pkg::REG_COUNT, got, alu_pkg::RESP_OKAY);
		check_value("op_count", alu_pkg::word_t'(ctrl_writes & 32'hFFFF), got);
		axil_write(alu_pkg::REG_RESULT, 32'hA5A5_5A5A, alu_pkg::RESP_SLVERR);   // Read-only
		axil_read(alu_pkg::REG_RESULT, got, alu_pkg::RESP_OKAY);
		check_value("result", last_result, got);
		axil_read(8'h20, got, alu_pkg::RESP_SLVERR);   // Unmapped
		check_value("rdata", 32'd0, got);
	endtask

	task automatic test_backpressure();
		alu_pkg::word_t got;
		ready_stall = 5;
		axil_write(alu_pkg::REG_A, 32'hC0DE_F00D, alu_pkg::RESP_OKAY);
		axil_read(alu_pkg::REG_A, got, alu_pkg::RESP_OKAY);
		check_value("operand_a", 32'hC0DE_F00D, got);
		ready_stall = 0;
	endtask

	initial begin
		void'($urandom(34642));
		clk     = 1'b0;
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = 4'hF;   // Whole words
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_overflow();
		test_random_ops();
		test_branch_movn();
		test_illegal();
		test_bus_errors();
		test_backpressure();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
